//--- rtl/tlb_entry_array.sv
`timescale 1ns/1ps

module tlb_entry_array #(
    parameter int   TLB_NUM = 16,
    localparam int  IDX_W   = $clog2(TLB_NUM)
) (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 wr_valid,
    input  logic [IDX_W-1:0]     wr_index,
    input  tlb_pkg::tlb_cmp_t    wr_cmp,
    input  tlb_pkg::tlb_half_t   wr_even,
    input  tlb_pkg::tlb_half_t   wr_odd,

    input  logic                 inv_valid,
    input  tlb_pkg::inv_op_t     inv_op,
    input  tlb_pkg::asid_t       inv_asid,
    input  tlb_pkg::vppn_t       inv_vppn,

    output tlb_pkg::tlb_cmp_t    cmp  [TLB_NUM-1:0],
    output tlb_pkg::tlb_half_t   even [TLB_NUM-1:0],
    output tlb_pkg::tlb_half_t   odd  [TLB_NUM-1:0]
);

    logic [TLB_NUM-1:0] g;
    logic [TLB_NUM-1:0] asid_eq;
    logic [TLB_NUM-1:0] vppn_eq;
    logic [TLB_NUM-1:0] inv_clr;

    // Per-entry invalidate decision
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            g[i]       = cmp[i][tlb_pkg::CMP_G_LSB];
            asid_eq[i] = cmp[i][tlb_pkg::CMP_ASID_LSB +: tlb_pkg::ASID_W] == inv_asid;
            // Full VPPN compare regardless of page size
            vppn_eq[i] = cmp[i][tlb_pkg::CMP_VPPN_LSB +: tlb_pkg::VPPN_W] == inv_vppn;
            case (inv_op)
                tlb_pkg::INV_ALL,
                tlb_pkg::INV_ALL_ALT: inv_clr[i] = 1'b1;
                tlb_pkg::INV_GLOBAL:  inv_clr[i] = g[i];
                tlb_pkg::INV_LOCAL:   inv_clr[i] = !g[i];
                tlb_pkg::INV_ASID:    inv_clr[i] = !g[i] && asid_eq[i];
                tlb_pkg::INV_ASID_VA: inv_clr[i] = !g[i] && asid_eq[i] && vppn_eq[i];
                tlb_pkg::INV_GA_VA:   inv_clr[i] = (g[i] || asid_eq[i]) && vppn_eq[i];
                default:              inv_clr[i] = 1'b0; // Unknown op, no effect
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                cmp[i]  <= '0;
                even[i] <= '0;
                odd[i]  <= '0;
            end
        end else if (wr_valid) begin // Write beats invalidate
            cmp[wr_index]  <= wr_cmp;
            even[wr_index] <= wr_even;
            odd[wr_index]  <= wr_odd;
        end else if (inv_valid) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (inv_clr[i])
                    cmp[i][tlb_pkg::CMP_E_LSB] <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/tlb_hit_stage.sv
`timescale 1ns/1ps

module tlb_hit_stage #(
    parameter int   TLB_NUM = 16,
    localparam int  IDX_W   = $clog2(TLB_NUM)
) (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 req_valid,
    input  tlb_pkg::va_t         req_va,
    input  logic                 req_store,
    input  tlb_pkg::asid_t       asid,

    input  tlb_pkg::tlb_cmp_t    cmp  [TLB_NUM-1:0],
    input  tlb_pkg::tlb_half_t   even [TLB_NUM-1:0],
    input  tlb_pkg::tlb_half_t   odd  [TLB_NUM-1:0],

    output logic                 s1_valid,
    output tlb_pkg::va_t         s1_va,
    output logic                 s1_store,
    output logic                 s1_hit,
    output tlb_pkg::tlb_half_t   s1_half,
    output logic                 s1_ps4m
);

    logic [TLB_NUM-1:0]  hit;
    logic [TLB_NUM-1:0]  is_4m;
    logic [TLB_NUM-1:0]  odd_sel;
    tlb_pkg::tlb_half_t  half_or;
    logic                ps4m_or;

    always_comb begin
        half_or = '0;
        ps4m_or = 1'b0;
        for (int i = 0; i < TLB_NUM; i++) begin
            is_4m[i]   = cmp[i][tlb_pkg::CMP_PS_LSB +: tlb_pkg::PS_W] == tlb_pkg::PS_4M;
            hit[i]     = tlb_pkg::entry_hits(cmp[i], asid, req_va[31:13]);
            odd_sel[i] = is_4m[i] ? req_va[21] : req_va[12]; // Even/odd page of the pair
            // At most one entry hits, so OR acts as the select
            if (hit[i]) begin
                half_or = half_or | (odd_sel[i] ? odd[i] : even[i]);
                ps4m_or = ps4m_or | is_4m[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            s1_valid <= 1'b0;
        else
            s1_valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_va    <= req_va;
            s1_store <= req_store;
            s1_hit   <= |hit;
            s1_half  <= half_or;
            s1_ps4m  <= ps4m_or;
        end
    end

endmodule

//--- rtl/tlb_mmu.sv
`timescale 1ns/1ps

module tlb_mmu #(
    parameter int   TLB_NUM = 16,
    localparam int  IDX_W   = $clog2(TLB_NUM)
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req_valid,
    input  tlb_pkg::va_t         req_va,
    input  logic                 req_store,
    input  logic                 wr_valid,
    input  logic [IDX_W-1:0]     wr_index,
    input  tlb_pkg::tlb_cmp_t    wr_cmp,
    input  tlb_pkg::tlb_half_t   wr_even,
    input  tlb_pkg::tlb_half_t   wr_odd,
    input  logic                 inv_valid,
    input  tlb_pkg::inv_op_t     inv_op,
    input  tlb_pkg::asid_t       inv_asid,
    input  tlb_pkg::vppn_t       inv_vppn,
    input  logic                 srch_valid,
    input  tlb_pkg::vppn_t       srch_vppn,
    input  tlb_pkg::asid_t       asid,
    input  logic                 pg,
    input  logic [1:0]           datm,
    input  logic [31:0]          dmw0,
    input  logic [31:0]          dmw1,
    output logic                 resp_valid,
    output tlb_pkg::pa_t         resp_pa,
    output logic                 resp_cached,
    output tlb_pkg::fault_t      resp_fault,
    output logic                 srch_done,
    output logic                 srch_hit,
    output logic [IDX_W-1:0]     srch_index
);

    tlb_pkg::tlb_cmp_t   cmp  [TLB_NUM-1:0];
    tlb_pkg::tlb_half_t  even [TLB_NUM-1:0];
    tlb_pkg::tlb_half_t  odd  [TLB_NUM-1:0];

    logic                s1_valid;
    tlb_pkg::va_t        s1_va;
    logic                s1_store;
    logic                s1_hit;
    tlb_pkg::tlb_half_t  s1_half;
    logic                s1_ps4m;

    tlb_entry_array #(.TLB_NUM(TLB_NUM)) u_entry_array (
        .clk       (clk),
        .rstn      (rstn),
        .wr_valid  (wr_valid),
        .wr_index  (wr_index),
        .wr_cmp    (wr_cmp),
        .wr_even   (wr_even),
        .wr_odd    (wr_odd),
        .inv_valid (inv_valid),
        .inv_op    (inv_op),
        .inv_asid  (inv_asid),
        .inv_vppn  (inv_vppn),
        .cmp       (cmp),
        .even      (even),
        .odd       (odd)
    );

    tlb_hit_stage #(.TLB_NUM(TLB_NUM)) u_hit_stage (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_va    (req_va),
        .req_store (req_store),
        .asid      (asid),
        .cmp       (cmp),
        .even      (even),
        .odd       (odd),
        .s1_valid  (s1_valid),
        .s1_va     (s1_va),
        .s1_store  (s1_store),
        .s1_hit    (s1_hit),
        .s1_half   (s1_half),
        .s1_ps4m   (s1_ps4m)
    );

    tlb_translate_stage u_translate_stage (
        .clk         (clk),
        .rstn        (rstn),
        .s1_valid    (s1_valid),
        .s1_va       (s1_va),
        .s1_store    (s1_store),
        .s1_hit      (s1_hit),
        .s1_half     (s1_half),
        .s1_ps4m     (s1_ps4m),
        .pg          (pg),
        .datm        (datm),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .resp_valid  (resp_valid),
        .resp_pa     (resp_pa),
        .resp_cached (resp_cached),
        .resp_fault  (resp_fault)
    );

    tlb_search #(.TLB_NUM(TLB_NUM)) u_search (
        .clk        (clk),
        .rstn       (rstn),
        .srch_valid (srch_valid),
        .srch_vppn  (srch_vppn),
        .asid       (asid),
        .cmp        (cmp),
        .srch_done  (srch_done),
        .srch_hit   (srch_hit),
        .srch_index (srch_index)
    );

endmodule

//--- rtl/tlb_pkg.sv
package tlb_pkg;

    localparam int ASID_W = 10;
    localparam int VPPN_W = 19;
    localparam int PPN_W  = 20;
    localparam int PS_W   = 6;
    localparam int MAT_W  = 2;

    typedef logic [31:0]       va_t;
    typedef logic [31:0]       pa_t;
    typedef logic [ASID_W-1:0] asid_t;
    typedef logic [VPPN_W-1:0] vppn_t;    // VA[31:13]
    typedef logic [PPN_W-1:0]  ppn_t;
    typedef logic [36:0]       tlb_cmp_t;  // E, ASID, G, PS, VPPN
    typedef logic [25:0]       tlb_half_t; // V, D, MAT, PLV, PPN
    typedef logic [1:0]        fault_t;
    typedef logic [4:0]        inv_op_t;

    localparam int CMP_VPPN_LSB = 0;
    localparam int CMP_PS_LSB   = 19;
    localparam int CMP_G_LSB    = 25;
    localparam int CMP_ASID_LSB = 26;
    localparam int CMP_E_LSB    = 36;

    // PLV occupies bits 21:20 and is not checked
    localparam int HALF_PPN_LSB = 0;
    localparam int HALF_MAT_LSB = 22;
    localparam int HALF_D_LSB   = 24;
    localparam int HALF_V_LSB   = 25;

    localparam logic [PS_W-1:0]  PS_4K      = 6'd12;
    localparam logic [PS_W-1:0]  PS_4M      = 6'd21;
    localparam logic [MAT_W-1:0] MAT_CACHED = 2'd1; // Coherent cached

    localparam int DMW_VSEG_LSB = 29;
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_MAT_LSB  = 4;
    localparam int DMW_PLV0_BIT = 0;
    localparam int DMW_PLV3_BIT = 3;

    localparam fault_t FAULT_NONE    = 2'd0;
    localparam fault_t FAULT_REFILL  = 2'd1;
    localparam fault_t FAULT_INVALID = 2'd2;
    localparam fault_t FAULT_MODIFY  = 2'd3;

    localparam inv_op_t INV_ALL     = 5'd0;
    localparam inv_op_t INV_ALL_ALT = 5'd1;
    localparam inv_op_t INV_GLOBAL  = 5'd2;
    localparam inv_op_t INV_LOCAL   = 5'd3;
    localparam inv_op_t INV_ASID    = 5'd4;
    localparam inv_op_t INV_ASID_VA = 5'd5;
    localparam inv_op_t INV_GA_VA   = 5'd6;

    function automatic logic entry_hits(tlb_cmp_t cmp, asid_t asid, vppn_t vppn);
        logic asid_ok;
        logic vppn_ok;
        asid_ok = cmp[CMP_G_LSB] || (cmp[CMP_ASID_LSB +: ASID_W] == asid);
        if (cmp[CMP_PS_LSB +: PS_W] == PS_4M)
            vppn_ok = cmp[CMP_VPPN_LSB + 9 +: 10] == vppn[VPPN_W-1:9]; // VA[31:22] only
        else
            vppn_ok = cmp[CMP_VPPN_LSB +: VPPN_W] == vppn;
        return cmp[CMP_E_LSB] && asid_ok && vppn_ok;
    endfunction

endpackage

//--- rtl/tlb_search.sv
`timescale 1ns/1ps

module tlb_search #(
    parameter int   TLB_NUM = 16,
    localparam int  IDX_W   = $clog2(TLB_NUM)
) (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 srch_valid,
    input  tlb_pkg::vppn_t       srch_vppn,
    input  tlb_pkg::asid_t       asid,
    input  tlb_pkg::tlb_cmp_t    cmp [TLB_NUM-1:0],

    output logic                 srch_done,
    output logic                 srch_hit,
    output logic [IDX_W-1:0]     srch_index
);

    logic [TLB_NUM-1:0] match;
    logic [IDX_W-1:0]   first_idx;

    // Scan downward so the lowest match wins, 0 on a miss
    always_comb begin
        first_idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            match[i] = tlb_pkg::entry_hits(cmp[i], asid, srch_vppn);
            if (match[i])
                first_idx = IDX_W'(i);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            srch_done <= 1'b0;
        else
            srch_done <= srch_valid;
    end

    always_ff @(posedge clk) begin
        if (srch_valid) begin
            srch_hit   <= |match;
            srch_index <= first_idx;
        end
    end

endmodule

//--- rtl/tlb_translate_stage.sv
`timescale 1ns/1ps

module tlb_translate_stage (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 s1_valid,
    input  tlb_pkg::va_t         s1_va,
    input  logic                 s1_store,
    input  logic                 s1_hit,
    input  tlb_pkg::tlb_half_t   s1_half,
    input  logic                 s1_ps4m,

    input  logic                 pg,
    input  logic [1:0]           datm,
    input  logic [31:0]          dmw0,
    input  logic [31:0]          dmw1,

    output logic                 resp_valid,
    output tlb_pkg::pa_t         resp_pa,
    output logic                 resp_cached,
    output tlb_pkg::fault_t      resp_fault
);

    // Window matches when segment agrees and some PLV enable is set
    function automatic logic dmw_hit(logic [31:0] dmw, tlb_pkg::va_t va);
        return (dmw[tlb_pkg::DMW_VSEG_LSB +: 3] == va[31:29]) &&
               (dmw[tlb_pkg::DMW_PLV0_BIT] || dmw[tlb_pkg::DMW_PLV3_BIT]);
    endfunction

    logic               dmw0_hit;
    logic               dmw1_hit;
    tlb_pkg::ppn_t      ppn;
    tlb_pkg::pa_t       tlb_pa;
    tlb_pkg::pa_t       pa_nxt;
    logic               cached_nxt;
    tlb_pkg::fault_t    fault_nxt;
    tlb_pkg::fault_t    tlb_fault;

    assign dmw0_hit = dmw_hit(dmw0, s1_va);
    assign dmw1_hit = dmw_hit(dmw1, s1_va);
    assign ppn      = s1_half[tlb_pkg::HALF_PPN_LSB +: tlb_pkg::PPN_W];
    assign tlb_pa   = s1_ps4m ? {ppn[19:9], s1_va[20:0]} : {ppn, s1_va[11:0]};

    always_comb begin
        if (!s1_hit)
            tlb_fault = tlb_pkg::FAULT_REFILL;
        else if (!s1_half[tlb_pkg::HALF_V_LSB])
            tlb_fault = tlb_pkg::FAULT_INVALID;
        else if (s1_store && !s1_half[tlb_pkg::HALF_D_LSB])
            tlb_fault = tlb_pkg::FAULT_MODIFY; // Store to clean page
        else
            tlb_fault = tlb_pkg::FAULT_NONE;
    end

    always_comb begin
        fault_nxt = tlb_pkg::FAULT_NONE;
        if (!pg) begin // Direct mode
            pa_nxt     = s1_va;
            cached_nxt = datm == tlb_pkg::MAT_CACHED;
        end else if (dmw0_hit) begin
            pa_nxt     = {dmw0[tlb_pkg::DMW_PSEG_LSB +: 3], s1_va[28:0]};
            cached_nxt = dmw0[tlb_pkg::DMW_MAT_LSB +: 2] == tlb_pkg::MAT_CACHED;
        end else if (dmw1_hit) begin
            pa_nxt     = {dmw1[tlb_pkg::DMW_PSEG_LSB +: 3], s1_va[28:0]};
            cached_nxt = dmw1[tlb_pkg::DMW_MAT_LSB +: 2] == tlb_pkg::MAT_CACHED;
        end else begin
            pa_nxt     = tlb_pa;
            cached_nxt = s1_half[tlb_pkg::HALF_MAT_LSB +: tlb_pkg::MAT_W] == tlb_pkg::MAT_CACHED;
            fault_nxt  = tlb_fault;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
            resp_fault <= tlb_pkg::FAULT_NONE;
        end else begin
            resp_valid <= s1_valid;
            if (s1_valid)
                resp_fault <= fault_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            resp_pa     <= pa_nxt;
            resp_cached <= cached_nxt;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tlb_mmu_tb -f tlb_mmu.f -o sim_tlb_mmu
out=$(./obj_dir/sim_tlb_mmu)
echo "$out"
echo "$out" | grep -q "Finished with no errors"

//--- tb/tlb_mmu_chk.sv
`timescale 1ns/1ps

module tlb_mmu_chk (
    input logic                 clk,
    input logic                 rstn,
    input logic                 req_valid,
    input logic                 resp_valid,
    input logic                 srch_valid,
    input logic                 srch_done,
    input logic                 pg,
    input tlb_pkg::fault_t      resp_fault
);

    resp_latency: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid == $past(req_valid, 2)) else $error("resp_valid not 2 cycles after req_valid");

    srch_latency: assert property (@(posedge clk) disable iff (!rstn)
        srch_done == $past(srch_valid)) else $error("srch_done not 1 cycle after srch_valid");

    // Direct mode never faults
    direct_no_fault: assert property (@(posedge clk) disable iff (!rstn)
        (resp_valid && !pg) |-> resp_fault == tlb_pkg::FAULT_NONE)
        else $error("fault raised with paging off");

endmodule

bind tlb_mmu tlb_mmu_chk u_chk (.*);

//--- tb/tlb_mmu_scoreboard.sv
`timescale 1ns/1ps

module tlb_mmu_scoreboard #(
    parameter int TLB_NUM = 16
) (
    input  logic clk, rstn, req_valid, req_store, wr_valid, inv_valid, srch_valid, pg,
    input  tlb_pkg::va_t req_va,
    input  logic [3:0] wr_index,
    input  tlb_pkg::tlb_cmp_t wr_cmp,
    input  tlb_pkg::tlb_half_t wr_even, wr_odd,
    input  tlb_pkg::inv_op_t inv_op,
    input  tlb_pkg::asid_t inv_asid, asid,
    input  tlb_pkg::vppn_t inv_vppn, srch_vppn,
    input  logic [1:0] datm,
    input  logic [31:0] dmw0, dmw1,
    input  logic resp_valid, resp_cached, srch_done, srch_hit,
    input  tlb_pkg::pa_t resp_pa,
    input  tlb_pkg::fault_t resp_fault,
    input  logic [3:0] srch_index,
    output int errors, checks, pending
);

    tlb_pkg::tlb_cmp_t  sh_cmp  [TLB_NUM];   // Shadow table
    tlb_pkg::tlb_half_t sh_even [TLB_NUM];
    tlb_pkg::tlb_half_t sh_odd  [TLB_NUM];
    logic [34:0]        exp_resp [$];         // {pa, cached, fault}
    logic [4:0]         exp_srch [$];         // {hit, index}

    initial begin
        errors = 0;
        checks = 0;
        pending = 0;
    end

    function automatic logic match(int i, tlb_pkg::asid_t a, tlb_pkg::vppn_t v);
        tlb_pkg::tlb_cmp_t c;
        logic big;
        c = sh_cmp[i];
        big = c[tlb_pkg::CMP_PS_LSB +: 6] == 6'd21;
        if (!c[tlb_pkg::CMP_E_LSB])
            return 1'b0;
        if (!c[tlb_pkg::CMP_G_LSB] && c[tlb_pkg::CMP_ASID_LSB +: 10] != a)
            return 1'b0;
        return big ? c[18:9] == v[18:9] : c[18:0] == v;
    endfunction

    function automatic logic [34:0] ref_translate(tlb_pkg::va_t va, logic st);
        logic [31:0] w;
        logic hit;
        logic big;
        tlb_pkg::tlb_half_t h;
        tlb_pkg::fault_t f;
        hit = 1'b0;
        big = 1'b0;
        h = '0;
        if (!pg)
            return {va, datm == 2'd1, 2'd0};
        for (int k = 0; k < 2; k++) begin
            w = (k == 0) ? dmw0 : dmw1;
            if (w[31:29] == va[31:29] && (w[0] || w[3]))
                return {w[27:25], va[28:0], w[5:4] == 2'd1, 2'd0};
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            if (!hit && match(i, asid, va[31:13])) begin
                hit = 1'b1;
                big = sh_cmp[i][tlb_pkg::CMP_PS_LSB +: 6] == 6'd21;
                h = (big ? va[21] : va[12]) ? sh_odd[i] : sh_even[i];
            end
        end
        if (!hit)
            f = 2'd1;
        else if (!h[tlb_pkg::HALF_V_LSB])
            f = 2'd2;
        else if (st && !h[tlb_pkg::HALF_D_LSB])
            f = 2'd3;
        else
            f = 2'd0;
        return {big ? {h[19:9], va[20:0]} : {h[19:0], va[11:0]},
                h[tlb_pkg::HALF_MAT_LSB +: 2] == 2'd1, f};
    endfunction

    function automatic logic [4:0] ref_search(tlb_pkg::vppn_t v);
        for (int i = 0; i < TLB_NUM; i++)
            if (match(i, asid, v))
                return {1'b1, 4'(i)};
        return 5'd0;
    endfunction

    function automatic logic inv_keeps(tlb_pkg::tlb_cmp_t c);
        logic g;
        logic a_eq;
        logic v_eq;
        g = c[tlb_pkg::CMP_G_LSB];
        a_eq = c[tlb_pkg::CMP_ASID_LSB +: 10] == inv_asid;
        v_eq = c[18:0] == inv_vppn;
        case (inv_op)
            5'd0, 5'd1: return 1'b0;
            5'd2: return !g;
            5'd3: return g;
            5'd4: return !(!g && a_eq);
            5'd5: return !(!g && a_eq && v_eq);
            5'd6: return !((g || a_eq) && v_eq);
            default: return 1'b1;
        endcase
    endfunction

    always @(posedge clk or negedge rstn) begin
        logic [34:0] e;
        logic [4:0]  s;
        if (!rstn) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                sh_cmp[i] = '0;
                sh_even[i] = '0;
                sh_odd[i] = '0;
            end
            exp_resp.delete();
            exp_srch.delete();
        end else begin
            if (resp_valid) begin
                checks++;
                if (exp_resp.size() == 0) begin
                    errors++;
                    $display("Response arrived at %0t with no request outstanding", $time);
                end else begin
                    e = exp_resp.pop_front();
                    // PA and cached flag carry no meaning on a refill
                    if (resp_fault != e[1:0] || (e[1:0] != 2'd1 &&
                            (resp_pa != e[34:3] || resp_cached != e[2]))) begin
                        errors++;
                        $display("FAILED %0t: pa %h cached %b fault %0d, expected %h %b %0d",
                                 $time, resp_pa, resp_cached, resp_fault,
                                 e[34:3], e[2], e[1:0]);
                    end
                end
            end
            if (srch_done) begin
                checks++;
                if (exp_srch.size() == 0) begin
                    errors++;
                    $display("Search result arrived at %0t with no search outstanding", $time);
                end else begin
                    s = exp_srch.pop_front();
                    if (srch_hit != s[4] || srch_index != s[3:0]) begin
                        errors++;
                        $display("FAILED %0t: search hit %b index %0d, expected %b %0d",
                                 $time, srch_hit, srch_index, s[4], s[3:0]);
                    end
                end
            end
            if (req_valid)
                exp_resp.push_back(ref_translate(req_va, req_store));
            if (srch_valid)
                exp_srch.push_back(ref_search(srch_vppn));
            if (wr_valid) begin
                sh_cmp[wr_index] = wr_cmp;
                sh_even[wr_index] = wr_even;
                sh_odd[wr_index] = wr_odd;
            end else if (inv_valid) begin
                for (int i = 0; i < TLB_NUM; i++)
                    if (!inv_keeps(sh_cmp[i]))
                        sh_cmp[i][tlb_pkg::CMP_E_LSB] = 1'b0;
            end
        end
        pending = exp_resp.size() + exp_srch.size();
    end

endmodule

//--- tb/tlb_mmu_tb.sv
`timescale 1ns/1ps

module tlb_mmu_tb;

    localparam int OPS = 360;   // Rough strobe count over all tests

    logic clk = 1'b0, rstn = 1'b0;
    logic req_valid, req_store, wr_valid, inv_valid, srch_valid, pg;
    tlb_pkg::va_t req_va;
    logic [3:0] wr_index;
    tlb_pkg::tlb_cmp_t wr_cmp;
    tlb_pkg::tlb_half_t wr_even, wr_odd;
    tlb_pkg::inv_op_t inv_op;
    tlb_pkg::asid_t inv_asid, asid;
    tlb_pkg::vppn_t inv_vppn, srch_vppn;
    logic [1:0] datm;
    logic [31:0] dmw0, dmw1;
    logic resp_valid, resp_cached, srch_done, srch_hit;
    tlb_pkg::pa_t resp_pa;
    tlb_pkg::fault_t resp_fault;
    logic [3:0] srch_index;
    int errors, checks, pending;
    int err_mark = 0;
    int seed = 32'h4aefdd1e;
    tlb_pkg::vppn_t tbl_vppn [8];

    tlb_mmu #(.TLB_NUM(16)) DUT (.*);
    tlb_mmu_scoreboard #(.TLB_NUM(16)) u_scoreboard (.*);

    always #2 clk = ~clk;

    function automatic tlb_pkg::tlb_cmp_t mk_cmp(logic e, tlb_pkg::asid_t a, logic g,
                                                  logic big, tlb_pkg::vppn_t v);
        mk_cmp = '0;
        mk_cmp[tlb_pkg::CMP_E_LSB] = e;
        mk_cmp[tlb_pkg::CMP_ASID_LSB +: 10] = a;
        mk_cmp[tlb_pkg::CMP_G_LSB] = g;
        mk_cmp[tlb_pkg::CMP_PS_LSB +: 6] = big ? 6'd21 : 6'd12;
        mk_cmp[tlb_pkg::CMP_VPPN_LSB +: 19] = v;
    endfunction

    function automatic tlb_pkg::tlb_half_t mk_half(logic v, logic d, logic [1:0] mat,
                                                    logic [19:0] ppn);
        mk_half = '0;
        mk_half[tlb_pkg::HALF_V_LSB] = v;
        mk_half[tlb_pkg::HALF_D_LSB] = d;
        mk_half[tlb_pkg::HALF_MAT_LSB +: 2] = mat;
        mk_half[tlb_pkg::HALF_PPN_LSB +: 20] = ppn;
    endfunction

    task automatic clear_strobes();
        req_valid = 1'b0;
        wr_valid = 1'b0;
        inv_valid = 1'b0;
        srch_valid = 1'b0;
    endtask

    task automatic send_req(tlb_pkg::va_t va, logic st);
        @(negedge clk);
        clear_strobes();
        req_valid = 1'b1;
        req_va = va;
        req_store = st;
    endtask

    task automatic write_entry(int idx, tlb_pkg::tlb_cmp_t c, tlb_pkg::tlb_half_t e,
                               tlb_pkg::tlb_half_t o);
        @(negedge clk);
        clear_strobes();
        wr_valid = 1'b1;
        wr_index = 4'(idx);
        wr_cmp = c;
        wr_even = e;
        wr_odd = o;
    endtask

    task automatic invalidate(int op, tlb_pkg::asid_t a, tlb_pkg::vppn_t v);
        @(negedge clk);
        clear_strobes();
        inv_valid = 1'b1;
        inv_op = 5'(op);
        inv_asid = a;
        inv_vppn = v;
    endtask

    task automatic search(tlb_pkg::vppn_t v);
        @(negedge clk);
        clear_strobes();
        srch_valid = 1'b1;
        srch_vppn = v;
    endtask

    // Let the pipeline drain before CSR inputs move
    task automatic finish_test(string name);
        @(negedge clk);
        clear_strobes();
        while (pending != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
        $display("%-12s done, %0d new errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic fill_table(tlb_pkg::asid_t a, tlb_pkg::asid_t b);
        for (int i = 0; i < 8; i++) begin
            tbl_vppn[i] = {4'(i), 15'($random(seed))};
            write_entry(i, mk_cmp(1'b1, i[0] ? a : b, i % 3 == 0, i == 5, tbl_vppn[i]),
                        mk_half(1'b1, 1'b1, 2'd1, 20'($random(seed))),
                        mk_half(1'b1, 1'b1, 2'd0, 20'($random(seed))));
        end
    endtask

    initial begin
        #((OPS * 8 + 16) * 4);
        $display("Timeout: the tests did not complete in the allowed time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic big;
        int base;
        clear_strobes();
        req_va = '0;
        req_store = 1'b0;
        wr_index = '0;
        wr_cmp = '0;
        wr_even = '0;
        wr_odd = '0;
        inv_op = '0;
        inv_asid = '0;
        inv_vppn = '0;
        srch_vppn = '0;
        asid = 10'h15;
        pg = 1'b0;
        datm = 2'd1;
        dmw0 = '0;
        dmw1 = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int n = 0; n < 32; n++) begin
            if (n == 16) begin
                finish_test("direct_c");
                datm = 2'd0;
            end
            send_req($random(seed), 1'($random(seed)));
        end
        finish_test("direct_uc");

        pg = 1'b1;
        dmw0 = {3'd4, 1'b0, 3'd1, 19'd0, 2'd1, 4'b0001};
        dmw1 = {3'd4, 1'b0, 3'd2, 19'd0, 2'd0, 4'b1000};
        for (int n = 0; n < 4; n++)
            send_req({3'd4, 29'($random(seed))}, 1'b0);
        finish_test("dmw0_prio");
        dmw0[3:0] = 4'b0000;    // DMW0 disabled, DMW1 takes over
        for (int n = 0; n < 4; n++)
            send_req({3'd4, 29'($random(seed))}, 1'b0);
        finish_test("dmw1");
        dmw1[3:0] = 4'b0000;
        send_req({3'd4, 29'($random(seed))}, 1'b0);
        finish_test("dmw_off");

        base = $random(seed) & 15;
        for (int k = 0; k < 6; k++) begin
            tbl_vppn[k] = {4'(k), 15'($random(seed))};
            write_entry((base + k * 3) % 16,
                        mk_cmp(1'b1, k[1] ? 10'h15 : 10'h2a, k == 0, k[0], tbl_vppn[k]),
                        mk_half(1'b1, 1'b1, 2'(k), 20'($random(seed))),
                        mk_half(1'b1, 1'b1, 2'(k + 1), 20'($random(seed))));
        end
        for (int r = 0; r < 2; r++) begin
            asid = r ? 10'h2a : 10'h15;
            for (int k = 0; k < 6; k++) begin
                big = k[0];
                for (int h = 0; h < 2; h++)
                    send_req(big ? {tbl_vppn[k][18:9], 1'(h), 21'($random(seed))}
                                 : {tbl_vppn[k], 1'(h), 12'($random(seed))}, 1'b0);
            end
            finish_test(r ? "tlb_asid_b" : "tlb_asid_a");
        end

        tbl_vppn[0] = 19'h7ab01;
        write_entry(0, mk_cmp(1'b1, asid, 1'b0, 1'b0, tbl_vppn[0]),
                    mk_half(1'b0, 1'b1, 2'd1, 20'h12345), mk_half(1'b1, 1'b0, 2'd1, 20'h6789a));
        send_req({19'h7ab00, 13'h0123}, 1'b0);  // Unmapped
        send_req({tbl_vppn[0], 13'h0456}, 1'b0);
        send_req({tbl_vppn[0], 13'h1456}, 1'b1);
        send_req({tbl_vppn[0], 13'h1789}, 1'b0);
        finish_test("faults");

        for (int op = 0; op < 8; op++) begin
            invalidate(0, '0, '0);
            fill_table(10'h15, 10'h2a);
            asid = 10'h15;
            invalidate(op, 10'h15, tbl_vppn[op == 6 ? 3 : 1]);
            for (int i = 0; i < 8; i++) begin
                send_req({tbl_vppn[i], 13'($random(seed))}, 1'b0);
                search(tbl_vppn[i]);
            end
            finish_test($sformatf("invtlb_op%0d", op));
        end

        invalidate(0, '0, '0);
        write_entry(9, mk_cmp(1'b1, 10'h0, 1'b1, 1'b0, 19'h1234f), '0, '0);
        write_entry(5, mk_cmp(1'b1, 10'h0, 1'b1, 1'b0, 19'h1234f), '0, '0);
        search(19'h1234f);
        search(19'h5234f);
        finish_test("search");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- tlb_mmu.f
rtl/tlb_pkg.sv
rtl/tlb_entry_array.sv
rtl/tlb_hit_stage.sv
rtl/tlb_translate_stage.sv
rtl/tlb_search.sv
rtl/tlb_mmu.sv
tb/tlb_mmu_chk.sv
tb/tlb_mmu_scoreboard.sv
tb/tlb_mmu_tb.sv
